// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;
    localparam int OP_W   = 4;
    localparam int FLAG_W = 4;

    // format bit set: ALU instruction
    typedef struct packed {
        logic            is_alu;
        logic [OP_W-1:0] op;
        logic            invert; // complements operand b
        logic [1:0]      bsel;
    } alu_view_t;

    // format bit clear: transfer instruction
    typedef struct packed {
        logic       is_alu;
        logic [2:0] kind;
        logic [1:0] spare;
        logic [1:0] rsel;
    } xfer_view_t;

    typedef union packed {
        alu_view_t  alu_view;
        xfer_view_t xfer_view;
    } ir_word_u;

    // ALU operations, other codes give zero
    localparam logic [OP_W-1:0] ALU_ADD   = 4'd0;
    localparam logic [OP_W-1:0] ALU_ADC   = 4'd1;
    localparam logic [OP_W-1:0] ALU_AND   = 4'd2;
    localparam logic [OP_W-1:0] ALU_OR    = 4'd3;
    localparam logic [OP_W-1:0] ALU_XOR   = 4'd4;
    localparam logic [OP_W-1:0] ALU_PASSB = 4'd5;

    // operand b sources
    localparam logic [1:0] BSEL_B    = 2'd0;
    localparam logic [1:0] BSEL_DPL  = 2'd1;
    localparam logic [1:0] BSEL_DPH  = 2'd2;
    localparam logic [1:0] BSEL_ZERO = 2'd3;

    // flag bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    // transfer kinds
    localparam logic [2:0] XF_LDI   = 3'd0;
    localparam logic [2:0] XF_LDM   = 3'd1;
    localparam logic [2:0] XF_STM   = 3'd2;
    localparam logic [2:0] XF_SWAP  = 3'd3;
    localparam logic [2:0] XF_FLAGS = 3'd4;
    localparam logic [2:0] XF_HALT  = 3'd5;

    // register select of XF_LDI
    localparam logic [1:0] RSEL_A   = 2'd0;
    localparam logic [1:0] RSEL_B   = 2'd1;
    localparam logic [1:0] RSEL_DPL = 2'd2;
    localparam logic [1:0] RSEL_DPH = 2'd3;

endpackage

`default_nettype wire

// ==== common/ctrl_if.sv ====
`default_nettype none

interface ctrl_if;

    logic [cpu_pkg::OP_W-1:0] alu_op;
    logic                     alu_invert;
    logic [1:0]               alu_bsel;

    logic we_a;
    logic we_b;
    logic we_flags;     // only with an ALU write of A
    logic a_from_flags;
    logic wd_b;         // store B instead of A

    logic ip_inc;
    logic addr_from_dp;
    logic swap;
    logic we_pl;
    logic we_ph;

    modport seq (
        output alu_op, alu_invert, alu_bsel,
        output we_a, we_b, we_flags, a_from_flags, wd_b,
        output ip_inc, addr_from_dp, swap, we_pl, we_ph
    );

    modport dp (
        input alu_op, alu_invert, alu_bsel,
        input we_a, we_b, we_flags, a_from_flags, wd_b
    );

    modport ptr (
        input ip_inc, addr_from_dp, swap, we_pl, we_ph
    );

endinterface

`default_nettype wire

// ==== datapath/alu.sv ====
`default_nettype none

module alu (
    input  logic [cpu_pkg::DATA_W-1:0] a,
    input  logic [cpu_pkg::DATA_W-1:0] b,
    input  logic [cpu_pkg::OP_W-1:0]   op,
    input  logic                       invert,
    input  logic                       carry_in,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic [cpu_pkg::FLAG_W-1:0] flags
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] b_eff;
    logic [DATA_W:0]   sum;
    logic              cin;
    logic              carry;
    logic              ovf;

    assign b_eff = invert ? ~b : b;
    assign cin   = (op == ALU_ADC) ? carry_in : 1'b0;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, cin};

    always_comb begin
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
                // same operand signs, result sign differs
                ovf    = (a[DATA_W-1] == b_eff[DATA_W-1]) &&
                         (sum[DATA_W-1] != a[DATA_W-1]);
            end
            ALU_AND:   result = a & b_eff;
            ALU_OR:    result = a | b_eff;
            ALU_XOR:   result = a ^ b_eff;
            ALU_PASSB: result = b_eff;
            default:   result = '0;
        endcase
    end

    always_comb begin
        flags         = '0;
        flags[FLAG_Z] = (result == '0);
        flags[FLAG_C] = carry;
        flags[FLAG_N] = result[DATA_W-1];
        flags[FLAG_V] = ovf;
    end

endmodule

`default_nettype wire

// ==== datapath/pointer_pair.sv ====
`default_nettype none

module pointer_pair #(
    parameter int                ADDR_W       = 16,
    parameter logic [ADDR_W-1:0] RESET_VECTOR = '0
) (
    input  logic                       nclk,
    input  logic                       rst,
    input  logic [cpu_pkg::DATA_W-1:0] di,
    output logic [ADDR_W-1:0]          addr,
    output logic [cpu_pkg::DATA_W-1:0] dpl,
    output logic [cpu_pkg::DATA_W-1:0] dph,
    ctrl_if.ptr                        ctl
);
    import cpu_pkg::*;

    logic [ADDR_W-1:0] p0_q;
    logic [ADDR_W-1:0] p1_q;
    logic              sel_q; // set: p1 is IP
    logic [ADDR_W-1:0] ip;
    logic [ADDR_W-1:0] dp;

    assign ip   = sel_q ? p1_q : p0_q;
    assign dp   = sel_q ? p0_q : p1_q;
    assign addr = ctl.addr_from_dp ? dp : ip;
    assign dpl  = dp[DATA_W-1:0];
    assign dph  = dp[ADDR_W-1 -: DATA_W];

    // IP and DP never name the same register, so updates do not collide
    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            p0_q  <= RESET_VECTOR;
            p1_q  <= '0;
            sel_q <= 1'b0;
        end else begin
            if (ctl.swap) begin
                sel_q <= ~sel_q;
            end
            if (ctl.ip_inc) begin
                if (sel_q) begin
                    p1_q <= p1_q + 1'b1;
                end else begin
                    p0_q <= p0_q + 1'b1;
                end
            end
            if (ctl.we_pl) begin
                if (sel_q) begin
                    p0_q[DATA_W-1:0] <= di;
                end else begin
                    p1_q[DATA_W-1:0] <= di;
                end
            end
            if (ctl.we_ph) begin
                if (sel_q) begin
                    p0_q[ADDR_W-1 -: DATA_W] <= di;
                end else begin
                    p1_q[ADDR_W-1 -: DATA_W] <= di;
                end
            end
        end
    end

    a_inc_swap_excl: assert property (@(posedge nclk) disable iff (!rst)
        !(ctl.ip_inc && ctl.swap));

endmodule

`default_nettype wire

// ==== datapath/datapath.sv ====
`default_nettype none

module datapath #(
    parameter int                 ADDR_W       = 16,
    parameter logic [ADDR_W-1:0]  RESET_VECTOR = '0
) (
    input  logic                       nclk,
    input  logic                       rst,
    input  logic [cpu_pkg::DATA_W-1:0] rdata,
    output logic [cpu_pkg::DATA_W-1:0] wdata,
    output logic [ADDR_W-1:0]          addr,
    ctrl_if.dp                         ctl,
    ctrl_if.ptr                        ptl
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    logic [FLAG_W-1:0] flags_q;
    logic [DATA_W-1:0] dpl;
    logic [DATA_W-1:0] dph;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_res;
    logic [FLAG_W-1:0] alu_flags;
    logic [DATA_W-1:0] a_next;

    always_comb begin
        case (ctl.alu_bsel)
            BSEL_B:   alu_b = b_q;
            BSEL_DPL: alu_b = dpl;
            BSEL_DPH: alu_b = dph;
            default:  alu_b = '0;
        endcase
    end

    // ALU writes always come with we_flags, otherwise A loads memory data
    always_comb begin
        if (ctl.a_from_flags) begin
            a_next = {{(DATA_W-FLAG_W){1'b0}}, flags_q};
        end else if (ctl.we_flags) begin
            a_next = alu_res;
        end else begin
            a_next = rdata;
        end
    end

    always_ff @(posedge nclk) begin
        if (ctl.we_a) begin
            a_q <= a_next;
        end
        if (ctl.we_b) begin
            b_q <= rdata;
        end
    end

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            flags_q <= '0;
        end else if (ctl.we_flags) begin
            flags_q <= alu_flags;
        end
    end

    assign wdata = ctl.wd_b ? b_q : a_q;

    alu u_alu (
        .a        (a_q),
        .b        (alu_b),
        .op       (ctl.alu_op),
        .invert   (ctl.alu_invert),
        .carry_in (flags_q[FLAG_C]),
        .result   (alu_res),
        .flags    (alu_flags)
    );

    pointer_pair #(
        .ADDR_W       (ADDR_W),
        .RESET_VECTOR (RESET_VECTOR)
    ) u_ptr (
        .nclk (nclk),
        .rst  (rst),
        .di   (rdata),
        .addr (addr),
        .dpl  (dpl),
        .dph  (dph),
        .ctl  (ptl)
    );

    a_flags_with_alu: assert property (@(posedge nclk) disable iff (!rst)
        ctl.we_flags |-> (ctl.we_a && !ctl.a_from_flags));

endmodule

`default_nettype wire

// ==== control/control_unit.sv ====
`default_nettype none

module control_unit #(
    parameter int ADDR_W = 16
) (
    input  logic                       nclk,
    input  logic                       rst,
    input  logic [cpu_pkg::DATA_W-1:0] rdata,
    output logic                       mem_oe,
    output logic                       mem_we,
    output logic                       halted,
    ctrl_if.seq                        ctl
);
    import cpu_pkg::*;

    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;
    localparam logic [1:0] S_HALT  = 2'd3;

    // no-op transfer of a free kind
    localparam logic [DATA_W-1:0] IR_IDLE = 8'h70;

    ir_word_u   ir_q;
    ir_word_u   fetched;
    logic [1:0] state_q;
    logic [1:0] state_d;

    // the pointer bytes are filled by two byte loads
    if (ADDR_W != 2 * DATA_W) begin : g_addr_chk
        $error("ADDR_W must be twice DATA_W");
    end

    assign fetched = rdata;
    assign halted  = (state_q == S_HALT);

    // operand fields go straight out
    assign ctl.alu_op     = ir_q.alu_view.op;
    assign ctl.alu_invert = ir_q.alu_view.invert;
    assign ctl.alu_bsel   = ir_q.alu_view.bsel;

    // reset parks in execute of a no-op
    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            state_q <= S_EXEC;
            ir_q    <= IR_IDLE;
        end else begin
            state_q <= state_d;
            if (state_q == S_FETCH) begin
                ir_q <= fetched;
            end
        end
    end

    always_comb begin
        state_d          = S_FETCH;
        mem_oe           = 1'b0;
        mem_we           = 1'b0;
        ctl.we_a         = 1'b0;
        ctl.we_b         = 1'b0;
        ctl.we_flags     = 1'b0;
        ctl.a_from_flags = 1'b0;
        ctl.wd_b         = 1'b0;
        ctl.ip_inc       = 1'b0;
        ctl.addr_from_dp = 1'b0;
        ctl.swap         = 1'b0;
        ctl.we_pl        = 1'b0;
        ctl.we_ph        = 1'b0;
        case (state_q)
            S_FETCH: begin
                mem_oe     = 1'b1;
                ctl.ip_inc = 1'b1;
                if (!fetched.xfer_view.is_alu && fetched.xfer_view.kind == XF_HALT) begin
                    state_d = S_HALT;
                end else begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                if (ir_q.alu_view.is_alu) begin
                    ctl.we_a     = 1'b1;
                    ctl.we_flags = 1'b1;
                end else begin
                    case (ir_q.xfer_view.kind)
                        XF_LDI: begin
                            mem_oe     = 1'b1; // immediate at IP
                            ctl.ip_inc = 1'b1;
                            ctl.we_a   = (ir_q.xfer_view.rsel == RSEL_A);
                            ctl.we_b   = (ir_q.xfer_view.rsel == RSEL_B);
                            ctl.we_pl  = (ir_q.xfer_view.rsel == RSEL_DPL);
                            ctl.we_ph  = (ir_q.xfer_view.rsel == RSEL_DPH);
                            state_d    = S_MEM;
                        end
                        XF_LDM, XF_STM: begin
                            ctl.addr_from_dp = 1'b1; // address setup
                            state_d          = S_MEM;
                        end
                        XF_SWAP: ctl.swap = 1'b1;
                        XF_FLAGS: begin
                            ctl.we_a         = 1'b1;
                            ctl.a_from_flags = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            S_MEM: begin
                // LDI only settles here
                if (!ir_q.xfer_view.is_alu && ir_q.xfer_view.kind == XF_LDM) begin
                    ctl.addr_from_dp = 1'b1;
                    mem_oe           = 1'b1;
                    ctl.we_a         = 1'b1;
                end
                if (!ir_q.xfer_view.is_alu && ir_q.xfer_view.kind == XF_STM) begin
                    ctl.addr_from_dp = 1'b1;
                    mem_we           = 1'b1;
                    ctl.wd_b         = (ir_q.xfer_view.rsel == RSEL_B);
                end
            end
            default: state_d = S_HALT; // stays until reset
        endcase
    end

    a_oe_we_excl: assert property (@(posedge nclk) disable iff (!rst)
        !(mem_oe && mem_we));

    a_halt_sticky: assert property (@(posedge nclk) disable iff (!rst)
        halted |=> halted);

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`default_nettype none

module cpu #(
    parameter int                ADDR_W       = 16,
    parameter logic [ADDR_W-1:0] RESET_VECTOR = '0
) (
    input  logic                       nclk,
    input  logic                       rst,
    output logic [ADDR_W-1:0]          addr,
    input  logic [cpu_pkg::DATA_W-1:0] rdata,
    output logic [cpu_pkg::DATA_W-1:0] wdata,
    output logic                       mem_oe,
    output logic                       mem_we,
    output logic                       halted
);

    ctrl_if ctl_bus ();

    control_unit #(
        .ADDR_W (ADDR_W)
    ) u_ctrl (
        .nclk   (nclk),
        .rst    (rst),
        .rdata  (rdata),
        .mem_oe (mem_oe),
        .mem_we (mem_we),
        .halted (halted),
        .ctl    (ctl_bus)
    );

    datapath #(
        .ADDR_W       (ADDR_W),
        .RESET_VECTOR (RESET_VECTOR)
    ) u_dp (
        .nclk  (nclk),
        .rst   (rst),
        .rdata (rdata),
        .wdata (wdata),
        .addr  (addr),
        .ctl   (ctl_bus),
        .ptl   (ctl_bus)
    );

endmodule

`default_nettype wire

// ==== verification/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam int                ADDR_W       = 16;
    localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'h0200;
    localparam logic [ADDR_W-1:0] SUB_ADDR     = 16'h0400; // target of the swap jump
    localparam int                TIMEOUT      = 200;

    logic              nclk;
    logic              rst;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] wdata;
    logic              mem_oe;
    logic              mem_we;
    logic              halted;

    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0] load_ptr;
    logic [ADDR_W-1:0] data_ptr;    // DP as the program sets it
    logic [FLAG_W-1:0] model_flags;
    logic [ADDR_W-1:0] rd_log [$];
    logic [ADDR_W-1:0] exp_waddr [$];
    logic [DATA_W-1:0] exp_wdata [$];
    int                last_oe_cycle;
    int                halt_cycle;
    int unsigned       seed;

    cpu #(
        .ADDR_W       (ADDR_W),
        .RESET_VECTOR (RESET_VECTOR)
    ) dut0 (
        .nclk   (nclk),
        .rst    (rst),
        .addr   (addr),
        .rdata  (rdata),
        .wdata  (wdata),
        .mem_oe (mem_oe),
        .mem_we (mem_we),
        .halted (halted)
    );

    assign rdata = mem[addr]; // combinational read

    always @(posedge nclk) begin
        if (mem_we === 1'b1) begin
            mem[addr] <= wdata;
        end
    end

    initial begin
        nclk = 1'b0;
        forever #2 nclk = ~nclk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(string name, logic [ADDR_W-1:0] got, logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_byte(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic emit_byte(logic [DATA_W-1:0] b);
        mem[load_ptr] = b;
        load_ptr      = load_ptr + 1'b1;
    endtask

    task automatic emit_alu(logic [OP_W-1:0] op, logic inv, logic [1:0] bsel);
        ir_word_u w;
        w.alu_view = {1'b1, op, inv, bsel};
        emit_byte(w);
    endtask

    task automatic emit_xfer(logic [2:0] kind, logic [1:0] rsel);
        ir_word_u w;
        w.xfer_view = {1'b0, kind, 2'b00, rsel};
        emit_byte(w);
    endtask

    task automatic emit_ldi(logic [1:0] rsel, logic [DATA_W-1:0] value);
        emit_xfer(XF_LDI, rsel);
        emit_byte(value);
    endtask

    task automatic point_dp(logic [ADDR_W-1:0] target);
        emit_ldi(RSEL_DPL, target[7:0]);
        emit_ldi(RSEL_DPH, target[15:8]);
        data_ptr = target;
    endtask

    task automatic expect_write(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d);
        exp_waddr.push_back(a);
        exp_wdata.push_back(d);
    endtask

    // reference ALU from the ISA rules returning {flags, result}
    function automatic logic [FLAG_W+DATA_W-1:0] model_alu(logic [OP_W-1:0] op,
            logic [DATA_W-1:0] a, logic [DATA_W-1:0] b, logic inv, logic cin);
        logic [DATA_W-1:0] bb;
        logic [DATA_W-1:0] r;
        logic [FLAG_W-1:0] f;
        int                us;
        int                ss;
        bb = inv ? ~b : b;
        f  = '0;
        us = int'(a) + int'(bb) + int'(op == ALU_ADC && cin);
        ss = int'($signed(a)) + int'($signed(bb)) + int'(op == ALU_ADC && cin);
        case (op)
            ALU_ADD, ALU_ADC: begin
                r         = us[DATA_W-1:0];
                f[FLAG_C] = (us > 255);
                f[FLAG_V] = (ss > 127) || (ss < -128); // outside signed byte range
            end
            ALU_AND:   r = a & bb;
            ALU_OR:    r = a | bb;
            ALU_XOR:   r = a ^ bb;
            ALU_PASSB: r = bb;
            default:   r = '0;
        endcase
        f[FLAG_Z] = (r == '0);
        f[FLAG_N] = r[DATA_W-1];
        return {f, r};
    endfunction

    // load A and B, run one ALU op, store A or the flags at DP
    task automatic alu_case(logic [OP_W-1:0] op, logic inv, logic [1:0] bsel,
            logic [DATA_W-1:0] ra, logic [DATA_W-1:0] rb, logic show_flags);
        logic [DATA_W-1:0]        bval;
        logic [FLAG_W+DATA_W-1:0] res;
        case (bsel)
            BSEL_B:   bval = rb;
            BSEL_DPL: bval = data_ptr[7:0];
            BSEL_DPH: bval = data_ptr[15:8];
            default:  bval = '0;
        endcase
        res         = model_alu(op, ra, bval, inv, model_flags[FLAG_C]);
        model_flags = res[DATA_W +: FLAG_W];
        emit_ldi(RSEL_A, ra);
        emit_ldi(RSEL_B, rb);
        emit_alu(op, inv, bsel);
        if (show_flags) begin
            emit_xfer(XF_FLAGS, 2'd0);
            expect_write(data_ptr, {{(DATA_W-FLAG_W){1'b0}}, model_flags});
        end else begin
            expect_write(data_ptr, res[DATA_W-1:0]);
        end
        emit_xfer(XF_STM, RSEL_A);
    endtask

    task automatic start_program();
        load_ptr    = RESET_VECTOR;
        model_flags = '0;
        exp_waddr.delete();
        exp_wdata.delete();
    endtask

    // close with HALT, reset, then watch the bus until halted
    task automatic run_program();
        int cycles;
        emit_xfer(XF_HALT, 2'd0);
        rd_log.delete();
        @(posedge nclk);
        #1 rst = 1'b0;
        repeat (3) @(posedge nclk);
        #1;
        check_bit("mem_oe", mem_oe, 1'b0);
        check_bit("mem_we", mem_we, 1'b0);
        check_bit("halted", halted, 1'b0);
        rst    = 1'b1;
        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                abort_run("CPU did not halt within 200 cycles");
            end
            @(negedge nclk);
            cycles++;
            if (mem_oe === 1'b1) begin
                rd_log.push_back(addr);
                last_oe_cycle = cycles;
            end
            if (mem_we === 1'b1) begin
                if (exp_waddr.size() == 0) begin
                    abort_run("CPU wrote memory where the program makes no store");
                end
                check_addr("addr", addr, exp_waddr.pop_front());
                check_byte("wdata", wdata, exp_wdata.pop_front());
            end
        end
        halt_cycle = cycles;
        if (exp_waddr.size() != 0) begin
            abort_run("CPU halted before making all expected stores");
        end
    endtask

    task automatic fetch_and_halt();
        start_program();
        emit_alu(ALU_PASSB, 1'b0, BSEL_ZERO);
        emit_alu(ALU_ADD, 1'b1, BSEL_ZERO);
        emit_alu(ALU_XOR, 1'b0, BSEL_ZERO);
        emit_alu(ALU_OR, 1'b1, BSEL_ZERO);
        run_program();
        if (rd_log.size() != 5) begin
            abort_run("wrong number of fetches for four ALU instructions and HALT");
        end
        for (int i = 0; i < 5; i++) begin
            check_addr("addr", rd_log[i], RESET_VECTOR + ADDR_W'(i));
        end
        if (halt_cycle != last_oe_cycle + 1) begin
            abort_run("halted did not rise in the cycle after the HALT fetch");
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge nclk);
            check_bit("mem_oe", mem_oe, 1'b0);
            check_bit("mem_we", mem_we, 1'b0);
            check_bit("halted", halted, 1'b1);
        end
    endtask

    task automatic load_store_immediates();
        logic [DATA_W-1:0] va;
        logic [DATA_W-1:0] vb;
        va = 8'($urandom);
        vb = 8'($urandom);
        start_program();
        emit_ldi(RSEL_A, va);
        emit_ldi(RSEL_B, vb);
        point_dp({1'b1, 15'($urandom)}); // data kept above the program area
        emit_xfer(XF_STM, RSEL_A);
        emit_xfer(XF_STM, RSEL_B);
        expect_write(data_ptr, va);
        expect_write(data_ptr, vb);
        run_program();
    endtask

    // every op code 0..7, each b source, both invert settings
    task automatic alu_operations();
        for (int k = 0; k < 8; k++) begin
            start_program();
            point_dp({1'b1, 15'($urandom)});
            for (int s = 0; s < 8; s++) begin
                alu_case(OP_W'(k), s[0], s[2:1], 8'($urandom), 8'($urandom), 1'b0);
            end
            run_program();
        end
    endtask

    task automatic flags_and_carry();
        logic [ADDR_W-1:0] x;
        logic [ADDR_W-1:0] y;
        logic [ADDR_W-1:0] sum;
        x   = 16'($urandom);
        y   = 16'($urandom);
        sum = x + y;
        start_program();
        point_dp({1'b1, 15'($urandom)});
        alu_case(ALU_ADD, 1'b0, BSEL_B, 8'h80, 8'h80, 1'b1);
        alu_case(ALU_ADD, 1'b0, BSEL_B, 8'h7f, 8'h01, 1'b1);
        alu_case(ALU_AND, 1'b0, BSEL_B, 8'h0f, 8'hf0, 1'b1);
        alu_case(ALU_ADD, 1'b1, BSEL_B, 8'h05, 8'h05, 1'b1);
        alu_case(ALU_ADC, 1'b0, BSEL_B, 8'($urandom), 8'($urandom), 1'b1);
        alu_case(ALU_XOR, 1'b0, BSEL_B, 8'($urandom), 8'($urandom), 1'b1);
        // 16-bit add with the high byte taking the low carry
        alu_case(ALU_ADD, 1'b0, BSEL_B, x[7:0], y[7:0], 1'b0);
        emit_ldi(RSEL_A, x[15:8]);
        emit_ldi(RSEL_B, y[15:8]);
        emit_alu(ALU_ADC, 1'b0, BSEL_B);
        emit_xfer(XF_STM, RSEL_A);
        expect_write(data_ptr, sum[15:8]);
        run_program();
    endtask

    task automatic load_and_swap();
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [ADDR_W-1:0] ret;
        logic [DATA_W-1:0] m;
        logic [DATA_W-1:0] x;
        src = {1'b1, 15'($urandom)};
        dst = src ^ 16'h0001;
        m   = 8'($urandom);
        x   = 8'($urandom);
        start_program();
        mem[src] = m;
        load_ptr = SUB_ADDR;
        emit_ldi(RSEL_A, x);
        emit_xfer(XF_SWAP, 2'd0);
        load_ptr = RESET_VECTOR;
        point_dp(src);
        emit_xfer(XF_LDM, 2'd0);
        point_dp(dst);
        emit_xfer(XF_STM, RSEL_A);
        point_dp(SUB_ADDR);
        emit_xfer(XF_SWAP, 2'd0);
        ret = load_ptr;
        point_dp(dst);
        emit_xfer(XF_STM, RSEL_A);
        expect_write(dst, m);
        expect_write(dst, x);
        run_program();
        // 4 DP reads, LDM fetch and load, 4 DP reads, STM fetch, 4 DP reads, swap fetch
        check_addr("LDM addr", rd_log[5], src);
        check_addr("fetch after swap", rd_log[16], SUB_ADDR);
        check_addr("fetch after second swap", rd_log[19], ret);
    endtask

    initial begin
        rst  = 1'b0;
        seed = 32'h0271f037;
        seed = $urandom(seed);
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = 8'(i >> 8) ^ 8'(i) ^ 8'h3c;
        end
        fetch_and_halt();
        load_store_immediates();
        alu_operations();
        flags_and_carry();
        load_and_swap();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu.f ====
common/cpu_pkg.sv
common/ctrl_if.sv
datapath/alu.sv
datapath/pointer_pair.sv
datapath/datapath.sv
control/control_unit.sv
design/cpu.sv
verification/cpu_tb.sv
